/* design/loader_pkg.sv */
package loader_pkg;

    // word and memory geometry
    localparam int DATA_WID  = 32;
    localparam int MEM_AWID  = 8;
    localparam int MEM_DEPTH = 256;

    // uart timing, small so simulation stays short
    localparam int CLKS_PER_BIT = 8;
    localparam int BIT_CNT_WID  = $clog2(CLKS_PER_BIT);

    // load frame: 4 address bytes then 4 data bytes, lsb first
    localparam int               FRAME_BYTES  = 8;
    localparam int               FRAME_WID    = 8 * FRAME_BYTES;
    localparam int               BYTE_CNT_WID = $clog2(FRAME_BYTES);
    localparam logic [31:0]      END_ADDR     = 32'hffff_ffff;

    // board io
    localparam int SWCH_WID  = 8;
    localparam int KEY_CNT   = 16;
    localparam int KBIDX_WID = 5;     // msb is the valid flag

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int DB_CNT_WID      = $clog2(DEBOUNCE_CYCLES);

    localparam int SEG_DIGITS   = 8;
    localparam int DIGIT_WID    = $clog2(SEG_DIGITS);
    localparam int SCAN_CYCLES  = 16;   // clocks each digit stays lit
    localparam int SCAN_CNT_WID = $clog2(SCAN_CYCLES);

    typedef enum logic [1:0] {idle, start, data, stop} rx_state_e;

    typedef enum logic [1:0] {collect, write_req, write_wait_ack_low, done} load_state_e;

    // one memory write, 40 bits
    typedef struct packed {
        logic [MEM_AWID-1:0] addr;
        logic [DATA_WID-1:0] data;
    } mem_wr_t;

    // nibble to segments {dp, g, f, e, d, c, b, a}, active low, dp dark
    function automatic logic [7:0] hex_to_seg(input logic [3:0] nib);
        logic [7:0] seg;
        case (nib)
            4'h0: seg = 8'hc0;
            4'h1: seg = 8'hf9;
            4'h2: seg = 8'ha4;
            4'h3: seg = 8'hb0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hf8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'ha: seg = 8'h88;
            4'hb: seg = 8'h83;
            4'hc: seg = 8'hc6;
            4'hd: seg = 8'ha1;
            4'he: seg = 8'h86;
            default: seg = 8'h8e;
        endcase
        return seg;
    endfunction

endpackage

/* design/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);
    import loader_pkg::*;

    logic                   rx_meta;
    logic                   rx_s;       // synchronized line
    rx_state_e              state;
    logic [BIT_CNT_WID-1:0] cnt;        // clocks within the current bit
    logic [2:0]             bit_idx;
    logic [7:0]             shift;
    logic                   mid_bit;    // end of a full bit period

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    assign mid_bit = (cnt == BIT_CNT_WID'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                idle: begin
                    cnt <= '0;
                    if (!rx_s)
                        state <= start;         // falling edge of start bit
                end
                start: begin
                    // wait half a bit to land in the middle of each bit
                    if (cnt == BIT_CNT_WID'(CLKS_PER_BIT / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? idle : data;  // short glitch, not a start
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                data: begin
                    cnt <= cnt + 1'b1;
                    if (mid_bit) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= stop;
                    end
                end
                stop: begin
                    cnt <= cnt + 1'b1;
                    if (mid_bit) begin
                        state    <= idle;
                        rx_valid <= rx_s;       // low stop bit drops the byte
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == data && mid_bit)
            shift <= {rx_s, shift[7:1]};
    end

    assign rx_byte = shift;

endmodule

/* design/uart_loader.sv */
`timescale 1ns/100ps

module uart_loader (
    input  logic                clk,
    input  logic                reset,
    input  logic [7:0]          rx_byte,
    input  logic                rx_valid,
    output loader_pkg::mem_wr_t wr,
    output logic                wr_req,
    input  logic                wr_ack,
    output logic                load_done
);
    import loader_pkg::*;

    load_state_e             state;
    logic [FRAME_WID-1:0]    frame;
    logic [FRAME_WID-1:0]    frame_word;    // frame including the current byte
    logic [BYTE_CNT_WID-1:0] byte_cnt;
    logic                    accepting;
    logic                    frame_full;
    logic                    frame_end;
    mem_wr_t                 frame_wr;
    mem_wr_t                 pend_wr;       // one-entry holding buffer
    logic                    pend_valid;
    logic                    end_pend;      // end frame seen, write still draining
    logic                    launch;
    logic                    capture;

    // after the end frame nothing more is taken in
    assign accepting  = (state != done) && !end_pend;
    assign frame_word = {rx_byte, frame[FRAME_WID-1:8]};
    assign frame_full = rx_valid && accepting
                        && (byte_cnt == BYTE_CNT_WID'(FRAME_BYTES - 1));
    assign frame_end  = (frame_word[31:0] == END_ADDR);

    assign frame_wr.addr = frame_word[MEM_AWID-1:0];  // upper address bits dropped
    assign frame_wr.data = frame_word[FRAME_WID-1 -: DATA_WID];

    // buffered frame goes out first
    assign launch  = (state == collect) && (pend_valid || (frame_full && !frame_end));
    assign capture = frame_full && !frame_end && ((state != collect) || pend_valid);

    always_ff @(posedge clk) begin
        if (rx_valid && accepting)
            frame <= frame_word;
    end

    always_ff @(posedge clk) begin
        if (launch)
            wr <= pend_valid ? pend_wr : frame_wr;
    end

    always_ff @(posedge clk) begin
        if (capture)
            pend_wr <= frame_wr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= collect;
            wr_req     <= 1'b0;
            byte_cnt   <= '0;
            pend_valid <= 1'b0;
            end_pend   <= 1'b0;
        end else begin
            if (rx_valid && accepting)
                byte_cnt <= byte_cnt + 1'b1;    // wraps once per frame
            if (frame_full && frame_end)
                end_pend <= 1'b1;

            case (state)
                collect: begin
                    if (launch) begin
                        wr_req     <= 1'b1;
                        pend_valid <= 1'b0;
                        state      <= write_req;
                    end else if (end_pend || (frame_full && frame_end)) begin
                        state <= done;
                    end
                end
                write_req: begin
                    if (wr_ack) begin
                        wr_req <= 1'b0;
                        state  <= write_wait_ack_low;
                    end
                end
                write_wait_ack_low: begin
                    if (!wr_ack)
                        state <= collect;   // handshake back to rest
                end
                done: ;                     // held until reset
            endcase

            // frame finished mid handshake waits here
            if (capture)
                pend_valid <= 1'b1;
        end
    end

    assign load_done = (state == done);

endmodule

/* design/program_mem.sv */
`timescale 1ns/100ps

module program_mem (
    input  logic                            clk,
    input  logic                            reset,
    input  loader_pkg::mem_wr_t             wr,
    input  logic                            wr_req,
    output logic                            wr_ack,
    input  logic [loader_pkg::MEM_AWID-1:0] rd_addr,
    output logic [loader_pkg::DATA_WID-1:0] rd_data
);
    import loader_pkg::*;

    logic [DATA_WID-1:0] mem [MEM_DEPTH];
    logic [MEM_AWID-1:0] sweep_addr;
    logic                sweep_busy;    // clearing after reset

    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_addr <= '0;
            sweep_busy <= 1'b1;
            wr_ack     <= 1'b0;
        end else if (sweep_busy) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (sweep_addr == MEM_AWID'(MEM_DEPTH - 1))
                sweep_busy <= 1'b0;
        end else begin
            // ack follows req one cycle later in both directions
            wr_ack <= wr_req;
        end
    end

    always_ff @(posedge clk) begin
        if (sweep_busy)
            mem[sweep_addr] <= '0;
        else if (wr_req && !wr_ack)     // first cycle of a request
            mem[wr.addr] <= wr.data;
    end

    // display read port, no latency
    assign rd_data = mem[rd_addr];

endmodule

/* design/keypad_encoder.sv */
`timescale 1ns/100ps

module keypad_encoder (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [loader_pkg::KEY_CNT-1:0]   kp,
    output logic [loader_pkg::KBIDX_WID-1:0] kb_idx
);
    import loader_pkg::*;

    logic [KBIDX_WID-1:0]  cand;        // raw priority result
    logic [KBIDX_WID-1:0]  cand_q;
    logic [DB_CNT_WID-1:0] stable_cnt;

    // lowest pressed line wins, so scan downward
    always_comb begin
        cand = '0;
        for (int i = KEY_CNT - 1; i >= 0; i--) begin
            if (kp[i])
                cand = {1'b1, (KBIDX_WID - 1)'(i)};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cand_q     <= '0;
            stable_cnt <= '0;
            kb_idx     <= '0;
        end else begin
            cand_q <= cand;
            if (cand != cand_q) begin
                stable_cnt <= '0;           // changed, start over
            end else if (stable_cnt != DB_CNT_WID'(DEBOUNCE_CYCLES - 1)) begin
                stable_cnt <= stable_cnt + 1'b1;
            end else begin
                kb_idx <= cand_q;           // held long enough
            end
        end
    end

endmodule

/* design/seg7_tube.sv */
`timescale 1ns/100ps

module seg7_tube (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [loader_pkg::DATA_WID-1:0]   data_in,
    output logic [loader_pkg::SEG_DIGITS-1:0] seg_en,
    output logic [7:0]                        seg_out
);
    import loader_pkg::*;

    logic [SCAN_CNT_WID-1:0] scan_cnt;
    logic [DIGIT_WID-1:0]    digit;     // digit currently lit
    logic [3:0]              nibble;

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else if (scan_cnt == SCAN_CNT_WID'(SCAN_CYCLES - 1)) begin
            scan_cnt <= '0;
            digit    <= digit + 1'b1;   // 7 wraps to 0
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // digit i shows nibble i, digit 0 is the least significant
    assign nibble  = data_in[{digit, 2'b00} +: 4];
    assign seg_en  = ~(SEG_DIGITS'(1) << digit);   // one enable low at a time
    assign seg_out = hex_to_seg(nibble);

endmodule

/* design/top.sv */
`timescale 1ns/100ps

module top (
    input  logic                              clk,
    input  logic                              reset,
    // serial program load
    input  logic                              rx,
    // board devices
    input  logic [loader_pkg::SWCH_WID-1:0]   switches,
    input  logic [loader_pkg::KEY_CNT-1:0]    kp,
    output logic [loader_pkg::SEG_DIGITS-1:0] seg_en,
    output logic [7:0]                        seg_out,
    output logic [5:0]                        led_out
);
    import loader_pkg::*;

    logic [7:0]           rx_byte;
    logic                 rx_valid;
    mem_wr_t              wr;
    logic                 wr_req;
    logic                 wr_ack;
    logic                 load_done;
    logic [DATA_WID-1:0]  rd_data;      // word under the switches
    logic [KBIDX_WID-1:0] kb_idx;

    uart_rx uart_rx_inst (
        .clk,
        .reset,
        .rx,
        .rx_byte,
        .rx_valid
    );

    uart_loader loader_inst (
        .clk,
        .reset,
        .rx_byte,
        .rx_valid,
        .wr,
        .wr_req,
        .wr_ack,
        .load_done
    );

    program_mem mem_inst (
        .clk,
        .reset,
        .wr,
        .wr_req,
        .wr_ack,
        .rd_addr(switches),
        .rd_data
    );

    seg7_tube seg7tube_inst (
        .clk,
        .reset,
        .data_in(rd_data),
        .seg_en,
        .seg_out
    );

    keypad_encoder keypad_inst (
        .clk,
        .reset,
        .kp,
        .kb_idx
    );

    assign led_out = {load_done, kb_idx};   // bit 5 load done, 4..0 key

endmodule

/* verification/top_asserts.sv */
`timescale 1ns/100ps

module top_asserts (
    input logic                              clk,
    input logic                              reset,
    input loader_pkg::mem_wr_t               wr,
    input logic                              wr_req,
    input logic                              wr_ack,
    input logic [loader_pkg::SEG_DIGITS-1:0] seg_en,
    input logic                              load_done
);

    // request held until the memory answers
    req_held: assert property (@(posedge clk) disable iff (reset)
        wr_req && !wr_ack |=> wr_req)
        else $error("wr_req fell before wr_ack");

    wr_stable: assert property (@(posedge clk) disable iff (reset)
        (wr_req || wr_ack) |=> $stable(wr))
        else $error("wr changed during a write handshake");

    // exactly one digit lit, enables active low
    digit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot(~seg_en))
        else $error("seg_en is not one-hot low");

    done_sticky: assert property (@(posedge clk) disable iff (reset)
        load_done |=> load_done)
        else $error("load_done fell without reset");

endmodule

bind top top_asserts top_checks (
    .clk,
    .reset,
    .wr,
    .wr_req,
    .wr_ack,
    .seg_en,
    .load_done
);

/* verification/tb_top.sv */
`timescale 1ns/100ps

module tb_top;
    import loader_pkg::*;

    localparam int ENTRIES    = 8;
    localparam int WAIT_LIMIT = 4000;   // cycles before any wait gives up

    typedef struct packed {
        logic [MEM_AWID-1:0]  addr;
        logic [DATA_WID-1:0]  data;
        logic [KEY_CNT-1:0]   keys;
        logic [KBIDX_WID-1:0] exp_idx;
    } stim_t;

    logic                  clk;
    logic                  reset;
    logic                  rx;
    logic [SWCH_WID-1:0]   switches;
    logic [KEY_CNT-1:0]    kp;
    logic [SEG_DIGITS-1:0] seg_en;
    logic [7:0]            seg_out;
    logic [5:0]            led_out;

    stim_t stim_tab [ENTRIES];
    int    seed = 46590;
    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    failed_tests = 0;
    int    write_count = 0;     // completed memory handshakes
    logic  ack_q = 1'b0;

    top UUT (.clk, .reset, .rx, .switches, .kp, .seg_en, .seg_out, .led_out);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (UUT.wr_ack && !ack_q)
            write_count <= write_count + 1;
        ack_q <= UUT.wr_ack;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timed out while waiting for %s", what);
    endtask

    task automatic end_test(input string name, input int err_base);
        tests++;
        if (errors == err_base) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d error(s)", tests, name, errors - err_base);
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic uart_send(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};     // stop, data, start
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            step(CLKS_PER_BIT);
        end
    endtask

    task automatic send_frame(input logic [31:0] addr, input logic [31:0] data);
        for (int i = 0; i < 4; i++)
            uart_send(addr[8*i +: 8]);
        for (int i = 0; i < 4; i++)
            uart_send(data[8*i +: 8]);
    endtask

    task automatic wait_writes(input int target);
        int n;
        n = 0;
        while (write_count < target && n < WAIT_LIMIT) begin
            step(1);
            n++;
        end
        if (write_count < target)
            report_timeout("the memory write handshake");
    endtask

    function automatic logic [7:0] digit_mask(input int d);
        return ~(8'h01 << d);
    endfunction

    // segments {dp, g..a} active low back to {valid, nibble}
    function automatic logic [4:0] decode_segment(input logic [7:0] seg);
        case (seg)
            8'hc0: return 5'h10;
            8'hf9: return 5'h11;
            8'ha4: return 5'h12;
            8'hb0: return 5'h13;
            8'h99: return 5'h14;
            8'h92: return 5'h15;
            8'h82: return 5'h16;
            8'hf8: return 5'h17;
            8'h80: return 5'h18;
            8'h90: return 5'h19;
            8'h88: return 5'h1a;
            8'h83: return 5'h1b;
            8'hc6: return 5'h1c;
            8'ha1: return 5'h1d;
            8'h86: return 5'h1e;
            8'h8e: return 5'h1f;
            default: return 5'h00;
        endcase
    endfunction

    // one full scan entered from digit 7 so every step 7..0..7 is seen
    task automatic read_display(output logic [31:0] word);
        logic [4:0] dec;
        int         n;
        int         prev;
        bit         ok;
        word = '0;
        ok   = 1'b1;
        @(negedge clk);
        n = 0;
        while (n < WAIT_LIMIT && seg_en != digit_mask(SEG_DIGITS - 1)) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            report_timeout("the last display digit");
            ok = 1'b0;
        end
        for (int i = 0; i < SEG_DIGITS && ok; i++) begin
            prev = (i + SEG_DIGITS - 1) % SEG_DIGITS;
            n = 0;
            while (n < WAIT_LIMIT && seg_en == digit_mask(prev)) begin
                @(negedge clk);
                n++;
            end
            if (n >= WAIT_LIMIT) begin
                report_timeout("the next display digit");
                ok = 1'b0;
            end else begin
                check_value("seg_en", 32'(seg_en), 32'(digit_mask(i)));
                dec = decode_segment(seg_out);
                if (!dec[4]) begin
                    errors++;
                    $display("digit %0d shows a pattern that is no hex digit", i);
                end
                word[4*i +: 4] = dec[3:0];
            end
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] seen;
        int          order [ENTRIES];
        int          j;
        int          tmp;
        int          n;
        int          e;
        int          base;
        int          target;

        reset    = 1'b1;
        rx       = 1'b1;
        switches = '0;
        kp       = '0;

        // address, data, key lines, expected key index
        stim_tab[0] = '{8'h00, 32'h0, 16'h0000, 5'h00};
        stim_tab[1] = '{8'h01, 32'h0, 16'h0001, 5'h10};
        stim_tab[2] = '{8'h17, 32'h0, 16'h0008, 5'h13};
        stim_tab[3] = '{8'h3c, 32'h0, 16'h8000, 5'h1f};
        stim_tab[4] = '{8'h80, 32'h0, 16'h0a40, 5'h16};
        stim_tab[5] = '{8'ha5, 32'h0, 16'hffff, 5'h10};
        stim_tab[6] = '{8'hfe, 32'h0, 16'h0300, 5'h18};
        stim_tab[7] = '{8'hff, 32'h0, 16'h4000, 5'h1e};
        for (int i = 0; i < ENTRIES; i++) begin
            stim_tab[i].data = $random(seed);
            order[i] = i;
        end

        step(4);
        reset = 1'b0;

        base = errors;
        n = 0;
        while (UUT.mem_inst.sweep_busy && n < WAIT_LIMIT) begin
            step(1);
            n++;
        end
        if (UUT.mem_inst.sweep_busy)
            report_timeout("the memory clear sweep");
        for (int s = 0; s < 3; s++) begin
            switches = SWCH_WID'(s * 85);
            read_display(word);
            check_value("display", word, 32'h0);
        end
        check_value("led_out", 32'(led_out), 32'h0);
        end_test("reset state", base);

        base = errors;
        for (int i = ENTRIES - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        target = write_count;
        for (int k = 0; k < ENTRIES; k++) begin
            // upper address bits vary and are dropped by the loader
            send_frame({8'h00, 16'(order[k]), stim_tab[order[k]].addr},
                       stim_tab[order[k]].data);
            target++;
            wait_writes(target);
        end
        for (int i = 0; i < ENTRIES; i++) begin
            switches = stim_tab[i].addr;
            read_display(word);
            check_value("display", word, stim_tab[i].data);
        end
        end_test("load and read back", base);

        base = errors;
        stim_tab[2].data = $random(seed);
        send_frame({24'h00_00ff, stim_tab[2].addr}, stim_tab[2].data);
        target++;
        wait_writes(target);
        switches = stim_tab[2].addr;
        read_display(word);
        check_value("display", word, stim_tab[2].data);
        end_test("overwrite", base);

        base = errors;
        send_frame(END_ADDR, 32'h1234_5678);
        n = 0;
        while (!led_out[5] && n < WAIT_LIMIT) begin
            step(1);
            n++;
        end
        if (!led_out[5])
            report_timeout("load_done on led_out[5]");
        send_frame({24'h0, stim_tab[0].addr}, ~stim_tab[0].data);
        switches = stim_tab[0].addr;
        read_display(word);
        check_value("display", word, stim_tab[0].data);
        check_value("write count", 32'(write_count), 32'(target));
        check_value("led_out[5]", 32'(led_out[5]), 32'h1);
        end_test("end of load", base);

        base = errors;
        for (int i = 0; i < ENTRIES; i++) begin
            e = (i + 1) % ENTRIES;      // no-key entry last so a release is seen
            kp = stim_tab[e].keys;
            n = 0;
            while (led_out[4:0] != stim_tab[e].exp_idx && n < WAIT_LIMIT) begin
                step(1);
                n++;
            end
            if (led_out[4:0] != stim_tab[e].exp_idx)
                report_timeout("the debounced key index");
            check_value("led_out[4:0]", 32'(led_out[4:0]), 32'(stim_tab[e].exp_idx));
            // glitch of DEBOUNCE_CYCLES-1 clocks
            seen = 32'(stim_tab[e].exp_idx);
            kp = ~stim_tab[e].keys;
            for (int c = 0; c < 3 * DEBOUNCE_CYCLES; c++) begin
                step(1);
                if (c == DEBOUNCE_CYCLES - 2)
                    kp = stim_tab[e].keys;
                if (led_out[4:0] != stim_tab[e].exp_idx)
                    seen = 32'(led_out[4:0]);
            end
            check_value("led_out[4:0] after glitch", seen, 32'(stim_tab[e].exp_idx));
        end
        end_test("keypad", base);

        base = errors;
        switches = stim_tab[5].addr;
        read_display(word);
        for (int d = 0; d < SEG_DIGITS; d++)
            check_value($sformatf("digit %0d", d), 32'(word[4*d +: 4]),
                        32'(stim_tab[5].data[4*d +: 4]));
        end_test("digit order", base);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
design/loader_pkg.sv
design/uart_rx.sv
design/uart_loader.sv
design/program_mem.sv
design/keypad_encoder.sv
design/seg7_tube.sv
design/top.sv
verification/top_asserts.sv
verification/tb_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f sim.f -o tb_top_sim

out=$(./obj_dir/tb_top_sim)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
